//--- Bender.yml
package:
  name: core_backend

sources:
  - include_dirs:
      - source
    files:
      - source/core_types_pkg.sv
      - source/wb_types_pkg.sv
      - source/operand_fetch.sv
      - source/forwarding.sv
      - source/alu.sv
      - source/execute.sv
      - source/memory_access.sv
      - source/core_backend.sv
  - target: test
    include_dirs:
      - source
      - tests
    files:
      - tests/core_backend_tb.sv

//--- all.f
+incdir+source
+incdir+tests
source/core_types_pkg.sv
source/wb_types_pkg.sv
source/operand_fetch.sv
source/forwarding.sv
source/alu.sv
source/execute.sv
source/memory_access.sv
source/core_backend.sv
tests/core_backend_tb.sv

//--- source/alu.sv
`include "core_consts.svh"

module alu (
  input  core_types_pkg::alu_op_e alu_op,
  input  logic [`XLEN-1:0]        a,
  input  logic [`XLEN-1:0]        b,
  output logic [`XLEN-1:0]        result,
  output logic                    compare
);
  import core_types_pkg::*;

  logic [$clog2(`XLEN)-1:0] shamt;

  // Shift amount from the low bits of b
  assign shamt = b[$clog2(`XLEN)-1:0];

  // Equality, used by SEQ for the write enable
  assign compare = (a == b);

  always_comb begin
    result = '0;
    case (alu_op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SRL: begin
        result = a >> shamt;
      end
      ALU_SRA: begin
        // Sign bit fills from the left
        result = $signed(a) >>> shamt;
      end
      ALU_SLT: begin
        result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      end
      ALU_SLTU: begin
        result = {{(`XLEN-1){1'b0}}, a < b};
      end
      ALU_SEQ: begin
        result = {{(`XLEN-1){1'b0}}, compare};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- source/core_backend.sv
module core_backend (
  input  logic                   bus,
  input  logic                   rst,
  input  core_types_pkg::issue_t issue,
  output logic                   issue_ready,
  output wb_types_pkg::wb_req_t  wb_req,
  input  wb_types_pkg::wb_rsp_t  wb_rsp,
  output core_types_pkg::wb_t    retire
);
  import core_types_pkg::*;

  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  logic    hold;

  // Register read, load-use bubble
  operand_fetch of_i (
    .bus         (bus),
    .rst         (rst),
    .issue       (issue),
    .hold        (hold),
    .wb          (retire),
    .issue_ready (issue_ready),
    .id_ex       (id_ex)
  );

  // Forwarding and ALU
  execute ex_i (
    .bus    (bus),
    .rst    (rst),
    .hold   (hold),
    .id_ex  (id_ex),
    .wb     (retire),
    .ex_mem (ex_mem)
  );

  // Data bus access, source of the pipeline hold
  memory_access ma_i (
    .bus    (bus),
    .rst    (rst),
    .ex_mem (ex_mem),
    .wb_rsp (wb_rsp),
    .wb_req (wb_req),
    .hold   (hold),
    .wb     (retire)
  );

endmodule

//--- source/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////

// Integer datapath width in bits
`define XLEN 32

// Architectural register count, x0 included
`define REG_COUNT 32

// Bits needed to index one register
`define REG_ADDR_W 5

//////////////////////////////////////////////////
// Data bus sizing
//////////////////////////////////////////////////

// Word address width on the Wishbone data port
`define WB_ADR_W 16

`endif

//--- source/core_types_pkg.sv
`include "core_consts.svh"

package core_types_pkg;

  // Decoded opcodes as issued to the back end
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    SEQ,
    LW,
    SW,
    NOP
  } op_e;

  // Operations the ALU itself knows about
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SEQ
  } alu_op_e;

  //////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////

  // Issue port, one decoded operation
  typedef struct packed {
    logic                    valid;
    op_e                     op;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`XLEN-1:0]        imm;
    logic                    use_imm;
  } issue_t;

  // ID/EX, operands already read
  typedef struct packed {
    logic                    valid;
    op_e                     op;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`XLEN-1:0]        rs1_val;
    logic [`XLEN-1:0]        rs2_val;
    logic [`XLEN-1:0]        imm;
    logic                    use_imm;
  } id_ex_t;

  // EX/MEM, ALU result or byte address of a load/store
  typedef struct packed {
    logic                    valid;
    op_e                     op;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    reg_write;
    logic [`XLEN-1:0]        result;
    logic [`XLEN-1:0]        store_data;
  } ex_mem_t;

  // MEM/WB, also the retire record
  typedef struct packed {
    logic                    valid;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    reg_write;
    logic [`XLEN-1:0]        value;
  } wb_t;

endpackage

//--- source/execute.sv
`include "core_consts.svh"

module execute (
  input  logic                    bus,
  input  logic                    rst,
  input  logic                    hold,
  input  core_types_pkg::id_ex_t  id_ex,
  input  core_types_pkg::wb_t     wb,
  output core_types_pkg::ex_mem_t ex_mem
);
  import core_types_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] store_data;
  logic [`XLEN-1:0] alu_result;
  logic             compare;
  logic             reg_write;
  alu_op_e          alu_op;

  // Operand bypass, EX/MEM fed back from this stage's own register
  forwarding fwd_i (
    .id_ex      (id_ex),
    .ex_mem     (ex_mem),
    .wb         (wb),
    .op_a       (op_a),
    .op_b       (op_b),
    .store_data (store_data)
  );

  alu alu_i (
    .alu_op  (alu_op),
    .a       (op_a),
    .b       (op_b),
    .result  (alu_result),
    .compare (compare)
  );

  //////////////////////////////////////////////////
  // Opcode to ALU operation, write enable
  //////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    reg_write = (id_ex.rd != '0);
    case (id_ex.op)
      SUB:  alu_op = ALU_SUB;
      AND:  alu_op = ALU_AND;
      OR:   alu_op = ALU_OR;
      XOR:  alu_op = ALU_XOR;
      SLL:  alu_op = ALU_SLL;
      SRL:  alu_op = ALU_SRL;
      SRA:  alu_op = ALU_SRA;
      SLT:  alu_op = ALU_SLT;
      SLTU: alu_op = ALU_SLTU;
      SEQ: begin
        // Written only when the compare holds
        alu_op    = ALU_SEQ;
        reg_write = (id_ex.rd != '0) && compare;
      end
      // Address add for loads and stores
      LW:   alu_op = ALU_ADD;
      SW: begin
        alu_op    = ALU_ADD;
        reg_write = 1'b0;
      end
      NOP:  reg_write = 1'b0;
      default: alu_op = ALU_ADD;
    endcase
  end

  //////////////////////////////////////////////////
  // EX/MEM register, frozen while memory holds
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.reg_write <= 1'b0;
    end else if (!hold) begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.op         <= id_ex.op;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.reg_write  <= id_ex.valid && reg_write;
      ex_mem.result     <= alu_result;
      ex_mem.store_data <= store_data;
    end
  end

endmodule

//--- source/forwarding.sv
`include "core_consts.svh"

module forwarding (
  input  core_types_pkg::id_ex_t  id_ex,
  input  core_types_pkg::ex_mem_t ex_mem,
  input  core_types_pkg::wb_t     wb,
  output logic [`XLEN-1:0]        op_a,
  output logic [`XLEN-1:0]        op_b,
  output logic [`XLEN-1:0]        store_data
);
  import core_types_pkg::*;

  logic [`XLEN-1:0] rs1_fwd;
  logic [`XLEN-1:0] rs2_fwd;

  // Newest producer wins: EX/MEM, then MEM/WB, then register file
  function automatic logic [`XLEN-1:0] pick(input logic [`REG_ADDR_W-1:0] rs,
                                             input logic [`XLEN-1:0]       rf_val);
    logic [`XLEN-1:0] val;
    if (rs == '0) begin
      val = '0;
    end else if (ex_mem.valid && ex_mem.reg_write && ex_mem.op != LW && ex_mem.rd == rs) begin
      // Load data not here yet, covered by the load-use bubble
      val = ex_mem.result;
    end else if (wb.valid && wb.reg_write && wb.rd == rs) begin
      val = wb.value;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  always_comb begin
    rs1_fwd = pick(id_ex.rs1, id_ex.rs1_val);
    rs2_fwd = pick(id_ex.rs2, id_ex.rs2_val);
  end

  assign op_a = rs1_fwd;

  // Immediate replaces rs2 on the ALU side only
  assign op_b       = id_ex.use_imm ? id_ex.imm : rs2_fwd;
  assign store_data = rs2_fwd;

endmodule

//--- source/memory_access.sv
`include "core_consts.svh"

module memory_access (
  input  logic                    bus,
  input  logic                    rst,
  input  core_types_pkg::ex_mem_t ex_mem,
  input  wb_types_pkg::wb_rsp_t   wb_rsp,
  output wb_types_pkg::wb_req_t   wb_req,
  output logic                    hold,
  output core_types_pkg::wb_t     wb
);
  import core_types_pkg::*;

  // Byte offset bits dropped from the word address
  localparam int off_w = $clog2(`XLEN/8);

  typedef enum logic {
    IDLE,
    ACCESS
  } state_e;

  state_e state;
  logic   mem_op;
  logic   done;

  assign mem_op = ex_mem.valid && (ex_mem.op == LW || ex_mem.op == SW);

  // Slave answered this cycle
  assign done = (state == ACCESS) && wb_rsp.ack;

  // Pipe frozen from entry of a load/store until its ack
  assign hold = ((state == IDLE) && mem_op) || ((state == ACCESS) && !wb_rsp.ack);

  //////////////////////////////////////////////////
  // Wishbone classic master
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      state      <= IDLE;
      wb_req.cyc <= 1'b0;
      wb_req.stb <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (mem_op) begin
            // Request stays stable until ack
            state        <= ACCESS;
            wb_req.cyc   <= 1'b1;
            wb_req.stb   <= 1'b1;
            wb_req.we    <= (ex_mem.op == SW);
            wb_req.sel   <= '1;
            wb_req.adr   <= ex_mem.result[`WB_ADR_W+off_w-1:off_w];
            wb_req.dat_w <= ex_mem.store_data;
          end
        end
        ACCESS: begin
          if (wb_rsp.ack) begin
            state      <= IDLE;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      wb.valid     <= 1'b0;
      wb.reg_write <= 1'b0;
    end else if (hold) begin
      // Nothing retires while waiting on the bus
      wb.valid     <= 1'b0;
      wb.reg_write <= 1'b0;
    end else begin
      wb.valid     <= ex_mem.valid;
      wb.rd        <= ex_mem.rd;
      wb.reg_write <= ex_mem.reg_write;
      // Load data taken in the ack cycle
      wb.value     <= (done && ex_mem.op == LW) ? wb_rsp.dat_r : ex_mem.result;
    end
  end

endmodule

//--- source/operand_fetch.sv
`include "core_consts.svh"

module operand_fetch (
  input  logic                   bus,
  input  logic                   rst,
  input  core_types_pkg::issue_t issue,
  input  logic                   hold,
  input  core_types_pkg::wb_t    wb,
  output logic                   issue_ready,
  output core_types_pkg::id_ex_t id_ex
);
  import core_types_pkg::*;

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic             ready_q;
  logic             load_use;
  logic             accept;

  // Register read with write-through of the retiring value
  function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
    logic [`XLEN-1:0] val;
    if (idx == '0) begin
      val = '0;
    end else if (wb.valid && wb.reg_write && wb.rd == idx) begin
      val = wb.value;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.value;
    end
  end

  //////////////////////////////////////////////////
  // Issue handshake
  //////////////////////////////////////////////////

  // Comes up one cycle after reset is released
  always_ff @(posedge bus) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  // Load still in ID/EX, its data not available before MEM/WB
  assign load_use = id_ex.valid && id_ex.op == LW && id_ex.rd != '0 && issue.valid &&
                    (id_ex.rd == issue.rs1 || id_ex.rd == issue.rs2);

  assign issue_ready = ready_q && !hold && !load_use;
  assign accept      = issue.valid && issue_ready;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
    end else if (hold) begin
      // Frozen entry keeps picking up register writes
      id_ex.rs1_val <= read_reg(id_ex.rs1);
      id_ex.rs2_val <= read_reg(id_ex.rs2);
    end else if (accept) begin
      id_ex.valid   <= 1'b1;
      id_ex.op      <= issue.op;
      id_ex.rd      <= issue.rd;
      id_ex.rs1     <= issue.rs1;
      id_ex.rs2     <= issue.rs2;
      id_ex.rs1_val <= read_reg(issue.rs1);
      id_ex.rs2_val <= read_reg(issue.rs2);
      id_ex.imm     <= issue.imm;
      id_ex.use_imm <= issue.use_imm;
    end else begin
      // Bubble, also on a load-use stall
      id_ex.valid <= 1'b0;
    end
  end

endmodule

//--- source/wb_types_pkg.sv
`include "core_consts.svh"

package wb_types_pkg;

  // Master to slave, Wishbone classic
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`XLEN/8-1:0]     sel;
    logic [`WB_ADR_W-1:0]   adr;
    logic [`XLEN-1:0]       dat_w;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                   ack;
    logic [`XLEN-1:0]       dat_r;
  } wb_rsp_t;

endpackage

//--- tests/core_ref_model.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

//////////////////////////////////////////////////
// Model state, updated in issue order
//////////////////////////////////////////////////

logic [`XLEN-1:0] model_regs [`REG_COUNT];
logic [`XLEN-1:0] model_mem [logic [`WB_ADR_W-1:0]];

// Stores still waiting for their bus cycle
wb_req_t exp_store [$];

// Power-up content of a memory word, from all address bits
function automatic logic [`XLEN-1:0] fill_word(input logic [`WB_ADR_W-1:0] adr);
  return {~adr, adr} ^ 32'h3c5a_0f96;
endfunction

function automatic void model_reset();
  for (int i = 0; i < `REG_COUNT; i++) begin
    model_regs[i] = '0;
  end
  model_mem.delete();
  exp_store.delete();
endfunction

// Expected retire record of one issued operation
function automatic wb_t ref_exec(input issue_t op);
  logic [`XLEN-1:0]     a;
  logic [`XLEN-1:0]     b;
  logic [`XLEN-1:0]     sum;
  logic [`XLEN-1:0]     res;
  logic [`WB_ADR_W-1:0] adr;
  logic                 wr;
  wb_req_t              req;
  wb_t                  rec;
  a   = (op.rs1 == '0) ? '0 : model_regs[op.rs1];
  b   = op.use_imm ? op.imm : ((op.rs2 == '0) ? '0 : model_regs[op.rs2]);
  sum = a + b;
  // Byte address, two offset bits dropped
  adr = sum[`WB_ADR_W+1:2];
  wr  = (op.rd != '0);
  res = '0;
  case (op.op)
    ADD:  res = sum;
    SUB:  res = a - b;
    AND:  res = a & b;
    OR:   res = a | b;
    XOR:  res = a ^ b;
    SLL:  res = a << b[4:0];
    SRL:  res = a >> b[4:0];
    SRA:  res = $signed(a) >>> b[4:0];
    SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
    SLTU: res = (a < b) ? 1 : 0;
    SEQ: begin
      // Only a true compare writes rd
      res = (a == b) ? 1 : 0;
      wr  = wr && (a == b);
    end
    LW: begin
      res = model_mem.exists(adr) ? model_mem[adr] : fill_word(adr);
    end
    SW: begin
      // Data is always rs2, never the immediate
      req.cyc   = 1'b1;
      req.stb   = 1'b1;
      req.we    = 1'b1;
      req.sel   = '1;
      req.adr   = adr;
      req.dat_w = (op.rs2 == '0) ? '0 : model_regs[op.rs2];
      model_mem[adr] = req.dat_w;
      exp_store.push_back(req);
      res = sum;
      wr  = 1'b0;
    end
    default: wr = 1'b0;
  endcase
  if (wr) begin
    model_regs[op.rd] = res;
  end
  rec.valid     = 1'b1;
  rec.rd        = op.rd;
  rec.reg_write = wr;
  rec.value     = res;
  return rec;
endfunction

`endif

//--- tests/core_backend_tb.sv
`include "core_consts.svh"

module core_backend_tb;
  import core_types_pkg::*;
  import wb_types_pkg::*;

  // Cycles any single wait may take
  localparam int wait_limit = 300;
  localparam int mem_words  = 1 << `WB_ADR_W;

  logic    bus;
  logic    rst;
  issue_t  issue;
  logic    issue_ready;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  wb_t     retire;

  integer stim_seed = 32'h2aff_cce7;
  integer wait_seed = 32'h2aff_cce7;

  wb_t   exp_wb [$];
  string cur_test;
  int    errors;
  int    checks;
  int    tests_run;
  int    tests_failed;
  int    errors_at_start;

  // Slave memory and its wait state counter
  logic [`XLEN-1:0] mem [mem_words];
  logic             busy;
  int               waits;

  `include "core_ref_model.svh"

  core_backend dut_i (
    .bus         (bus),
    .rst         (rst),
    .issue       (issue),
    .issue_ready (issue_ready),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .retire      (retire)
  );

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_wb(input string name, input wb_t exp, input wb_t act);
    logic bad;
    bad = (act.rd !== exp.rd) || (act.reg_write !== exp.reg_write);
    // Value only matters when rd is written
    if (exp.reg_write && act.value !== exp.value) begin
      bad = 1'b1;
    end
    checks++;
    if (bad) begin
      errors++;
      $display("[FAIL] %s retire expected rd %0d we %b value %h, %s %0d we %b value %h",
               name, exp.rd, exp.reg_write, exp.value, "actual rd",
               act.rd, act.reg_write, act.value);
    end
  endtask

  task automatic check_req(input string name, input wb_req_t exp, input wb_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s store expected adr %h data %h we %b sel %h, %s %h data %h we %b sel %h",
               name, exp.adr, exp.dat_w, exp.we, exp.sel, "actual adr",
               act.adr, act.dat_w, act.we, act.sel);
    end
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  task automatic end_run();
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  task automatic timeout_stop(input string what);
    errors++;
    $display("%s: gave up after %0d cycles waiting for %s", cur_test, wait_limit, what);
    end_run();
  endtask

  // Entered and left one time unit after a rising edge
  task automatic issue_op(input issue_t op);
    int waited;
    waited = 0;
    exp_wb.push_back(ref_exec(op));
    issue = op;
    #1;
    while (!issue_ready) begin
      @(posedge bus);
      #2;
      waited++;
      if (waited > wait_limit) begin
        timeout_stop("issue_ready");
      end
    end
    @(posedge bus);
    #1;
    issue.valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_wb.size() != 0) begin
      @(posedge bus);
      #1;
      waited++;
      if (waited > wait_limit) begin
        timeout_stop("the pipeline to retire everything");
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    wait_drain();
    if (exp_store.size() != 0) begin
      errors++;
      $display("%s: %0d stores never reached the bus", cur_test, exp_store.size());
    end
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
    end
    $display("%-16s done, %0d errors", cur_test, errors - errors_at_start);
  endtask

  function automatic issue_t make_issue(input op_e op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [`XLEN-1:0] imm, input logic use_imm);
    issue_t it;
    it.valid   = 1'b1;
    it.op      = op;
    it.rd      = rd;
    it.rs1     = rs1;
    it.rs2     = rs2;
    it.imm     = imm;
    it.use_imm = use_imm;
    return it;
  endfunction

  // ADD from x0 with an immediate
  task automatic load_reg(input logic [4:0] rd, input logic [`XLEN-1:0] val);
    issue_op(make_issue(ADD, rd, 5'd0, 5'd0, val, 1'b1));
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic reset_idle();
    begin_test("reset_idle");
    repeat (10) begin
      @(posedge bus);
      #1;
      checks++;
      if (retire.valid || wb_req.cyc || wb_req.stb) begin
        errors++;
        $display("%s: retire or bus cycle active before any issue", cur_test);
      end
    end
    checks++;
    if (!issue_ready) begin
      errors++;
      $display("%s: issue_ready did not come up after reset", cur_test);
    end
    end_test();
  endtask

  task automatic alu_coverage();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    begin_test("alu_ops");
    for (int i = 0; i < 12; i++) begin
      a = (i == 0) ? 32'h8000_0005 : $random(stim_seed);
      b = (i == 0) ? 32'h0000_0023 : $random(stim_seed);
      // Equal operands once for SEQ
      if (i == 1) begin
        b = a;
      end
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      for (int k = 0; k <= int'(SEQ); k++) begin
        issue_op(make_issue(op_e'(k), 5'd3, 5'd1, 5'd2, '0, 1'b0));
        issue_op(make_issue(op_e'(k), 5'd4, 5'd1, 5'd0, b, 1'b1));
      end
    end
    end_test();
  endtask

  task automatic forwarding_chain();
    int k;
    begin_test("forwarding");
    load_reg(5'd5, 32'd7);
    issue_op(make_issue(ADD, 5'd5, 5'd5, 5'd5, '0, 1'b0));
    issue_op(make_issue(SUB, 5'd6, 5'd5, 5'd0, 32'd1, 1'b1));
    issue_op(make_issue(ADD, 5'd7, 5'd5, 5'd6, '0, 1'b0));
    issue_op(make_issue(XOR, 5'd8, 5'd5, 5'd7, '0, 1'b0));
    // x0 stays zero after a write
    issue_op(make_issue(ADD, 5'd0, 5'd5, 5'd0, 32'd99, 1'b1));
    issue_op(make_issue(OR, 5'd9, 5'd0, 5'd0, '0, 1'b0));
    for (int i = 0; i < 40; i++) begin
      k = $unsigned($random(stim_seed)) % (int'(SEQ) + 1);
      issue_op(make_issue(op_e'(k), 5'($unsigned($random(stim_seed)) % 4),
                          5'($unsigned($random(stim_seed)) % 4),
                          5'($unsigned($random(stim_seed)) % 4),
                          $random(stim_seed), 1'($random(stim_seed))));
    end
    end_test();
  endtask

  task automatic store_load_pair();
    begin_test("store_load");
    for (int i = 0; i < 10; i++) begin
      load_reg(5'd1, $random(stim_seed) & 32'h0003_fffc);
      load_reg(5'd2, $random(stim_seed));
      issue_op(make_issue(SW, 5'd0, 5'd1, 5'd2, 32'(4 * i), 1'b1));
      issue_op(make_issue(LW, 5'd3, 5'd1, 5'd0, 32'(4 * i), 1'b1));
      // Store data forwarded from the load just before
      issue_op(make_issue(SW, 5'd0, 5'd1, 5'd3, 32'h40, 1'b1));
      issue_op(make_issue(LW, 5'd4, 5'd1, 5'd0, 32'h40, 1'b1));
    end
    end_test();
  endtask

  task automatic load_use_pair();
    begin_test("load_use");
    for (int i = 0; i < 8; i++) begin
      issue_op(make_issue(LW, 5'd5, 5'd0, 5'd0, 32'(16 * i), 1'b1));
      issue_op(make_issue(ADD, 5'd6, 5'd5, 5'd5, '0, 1'b0));
      issue_op(make_issue(LW, 5'd7, 5'd0, 5'd0, 32'(16 * i + 4), 1'b1));
      issue_op(make_issue(SW, 5'd0, 5'd0, 5'd7, 32'h200, 1'b1));
      issue_op(make_issue(LW, 5'd8, 5'd0, 5'd0, 32'h200, 1'b1));
      issue_op(make_issue(SUB, 5'd9, 5'd6, 5'd8, '0, 1'b0));
    end
    end_test();
  endtask

  task automatic seq_writes();
    begin_test("seq");
    load_reg(5'd1, 32'd42);
    load_reg(5'd2, 32'd42);
    load_reg(5'd3, 32'd5);
    load_reg(5'd5, 32'd77);
    issue_op(make_issue(SEQ, 5'd4, 5'd1, 5'd2, '0, 1'b0));
    // Unequal, x5 keeps 77
    issue_op(make_issue(SEQ, 5'd5, 5'd1, 5'd3, '0, 1'b0));
    issue_op(make_issue(ADD, 5'd6, 5'd5, 5'd0, '0, 1'b0));
    issue_op(make_issue(SEQ, 5'd7, 5'd1, 5'd0, 32'd42, 1'b1));
    issue_op(make_issue(ADD, 5'd8, 5'd4, 5'd7, '0, 1'b0));
    end_test();
  endtask

  task automatic random_stream();
    issue_t it;
    int     k;
    begin_test("random_stream");
    for (int i = 0; i < 200; i++) begin
      k  = $unsigned($random(stim_seed)) % 14;
      it = make_issue(op_e'(k), 5'($unsigned($random(stim_seed)) % 8),
                      5'($unsigned($random(stim_seed)) % 8),
                      5'($unsigned($random(stim_seed)) % 8),
                      $random(stim_seed), 1'($random(stim_seed)));
      if (it.op == LW || it.op == SW) begin
        it.use_imm = 1'b1;
      end
      issue_op(it);
    end
    end_test();
  endtask

  //////////////////////////////////////////////////
  // Wishbone slave model
  //////////////////////////////////////////////////

  always @(posedge bus) begin
    #1;
    if (rst) begin
      wb_rsp.ack = 1'b0;
      busy       = 1'b0;
    end else if (wb_rsp.ack) begin
      // One-cycle ack, master drops cyc now
      wb_rsp.ack = 1'b0;
      busy       = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!busy) begin
        busy  = 1'b1;
        waits = $unsigned($random(wait_seed)) % 4;
      end
      if (waits == 0) begin
        wb_rsp.ack = 1'b1;
        if (wb_req.we) begin
          if (exp_store.size() == 0) begin
            errors++;
            $display("%s: store on the bus that was never issued", cur_test);
          end else begin
            check_req(cur_test, exp_store.pop_front(), wb_req);
          end
          mem[wb_req.adr] = wb_req.dat_w;
        end else begin
          wb_rsp.dat_r = mem[wb_req.adr];
        end
      end else begin
        waits--;
      end
    end
  end

  //////////////////////////////////////////////////
  // Retire compare process
  //////////////////////////////////////////////////

  initial begin
    wb_t exp;
    forever begin
      @(posedge bus);
      #2;
      if (!rst && retire.valid) begin
        if (exp_wb.size() == 0) begin
          errors++;
          $display("%s: an operation retired with nothing left to expect", cur_test);
        end else begin
          exp = exp_wb.pop_front();
          check_wb(cur_test, exp, retire);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    rst      = 1'b1;
    issue    = '0;
    wb_rsp   = '0;
    busy     = 1'b0;
    waits    = 0;
    cur_test = "reset";
    model_reset();
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill_word(i[`WB_ADR_W-1:0]);
    end
    repeat (16) @(posedge bus);
    #1;
    rst = 1'b0;
    reset_idle();
    alu_coverage();
    forwarding_chain();
    store_load_pair();
    load_use_pair();
    seq_writes();
    random_stream();
    end_run();
  end

endmodule
